//--- verilog.f
+incdir+.
uoramCmdPkg.sv
uoramStreamPkg.sv
uoramReqControl.sv
uoramDataRouter.sv
leafFifo.sv
widthFunnel.sv
uoramSubsystem.sv
uoramTb.sv

//--- uoramTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uoramConsts.svh"

module uoramTb;

    import uoramCmdPkg::*;
    import uoramStreamPkg::*;

    localparam int numTests      = 6;
    localparam int cyclesPerTest = 200;
    localparam int clkPeriod     = 4;
    localparam int chunks        = `UORAM_BLOCK_CHUNKS;
    localparam int leaves        = `UORAM_BLOCK_LEAVES;

    logic       Clock = 1'b0;
    logic       rstN;
    logic       feReqValid;
    logic       feReqReady;
    feRequest_t feReq;
    logic       beCommandValid;
    logic       beCommandReady = 1'b0;
    feRequest_t beCommand;
    logic       expectingProgramData;
    logic       dataInValid;
    logic       dataInReady;
    chunk_t     dataIn;
    logic       returnDataValid;
    logic       returnDataReady = 1'b0;
    chunk_t     returnData;
    logic       evictLeafValid;
    logic       evictLeafReady;
    leaf_t      evictLeaf;
    logic       refillLeafValid;
    logic       refillLeafReady = 1'b0;
    leaf_t      refillLeaf;
    logic       storeValid;
    logic       storeReady = 1'b0;
    chunk_t     store;
    logic       loadValid = 1'b0;
    logic       loadReady;
    chunk_t     load = '0;

    integer seed = 94;
    int     errors = 0;
    int     testsDone = 0;
    logic   stallHeavy;

    // reference state, built from what the testbench drove
    feRequest_t expReq;
    int         reqsOpen;
    int         accepted;
    int         issued;
    logic       expExpect;
    chunk_t     expStore [16];
    int         storeWr = 0;
    int         storeCount;
    chunk_t     expReturn [16];
    int         returnWr = 0;
    int         returnCount;
    leaf_t      expRefill [16];
    int         refillWr = 0;
    int         refillCount;
    chunk_t     shadowChunk [int];
    leaf_t      shadowLeaf [int];

    // backend model
    chunk_t                   beMem [1 << (`UORAM_ADDR_W + 2)];
    logic                     beBusy;
    logic                     beIsRead;
    logic [`UORAM_ADDR_W-1:0] beAddr;
    logic [1:0]               beIdx;
    logic                     beat;

    uoramSubsystem dut (
        .Clock                (Clock),
        .rstN                 (rstN),
        .feReqValid           (feReqValid),
        .feReqReady           (feReqReady),
        .feReq                (feReq),
        .beCommandValid       (beCommandValid),
        .beCommandReady       (beCommandReady),
        .beCommand            (beCommand),
        .expectingProgramData (expectingProgramData),
        .dataInValid          (dataInValid),
        .dataInReady          (dataInReady),
        .dataIn               (dataIn),
        .returnDataValid      (returnDataValid),
        .returnDataReady      (returnDataReady),
        .returnData           (returnData),
        .evictLeafValid       (evictLeafValid),
        .evictLeafReady       (evictLeafReady),
        .evictLeaf            (evictLeaf),
        .refillLeafValid      (refillLeafValid),
        .refillLeafReady      (refillLeafReady),
        .refillLeaf           (refillLeaf),
        .storeValid           (storeValid),
        .storeReady           (storeReady),
        .store                (store),
        .loadValid            (loadValid),
        .loadReady            (loadReady),
        .load                 (load)
    );

    always #(clkPeriod / 2) Clock = ~Clock;

    function automatic logic readyDraw();
        logic [1:0] r;
        r = $random(seed);
        // heavy stall gives ready one cycle in four
        return stallHeavy ? (r == 2'd0) : (r != 2'd0);
    endfunction

    always @(posedge Clock) begin
        if (!rstN) begin
            beCommandReady  <= 1'b0;
            storeReady      <= 1'b0;
            returnDataReady <= 1'b0;
            refillLeafReady <= 1'b0;
        end else begin
            beCommandReady  <= readyDraw();
            storeReady      <= readyDraw();
            returnDataReady <= readyDraw();
            refillLeafReady <= readyDraw();
        end
    end

    assign beat = beBusy && ((!beIsRead && storeValid && storeReady) ||
                             (beIsRead && loadValid && loadReady));

    // backend captures four chunks per write and plays them back on load for a read
    always @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            beBusy    <= 1'b0;
            beIsRead  <= 1'b0;
            beIdx     <= '0;
            loadValid <= 1'b0;
        end else if (beCommandValid && beCommandReady) begin
            beBusy   <= 1'b1;
            beIsRead <= beCommand.command inside {cmdRead, cmdReadRmv};
            beAddr   <= beCommand.addr;
            beIdx    <= '0;
            if (beCommand.command inside {cmdRead, cmdReadRmv}) begin
                loadValid <= 1'b1;
                load      <= beMem[{beCommand.addr, 2'd0}];
            end
        end else if (beat) begin
            beIdx <= beIdx + 2'd1;
            if (!beIsRead) begin
                beMem[{beAddr, beIdx}] <= store;
            end else begin
                load <= beMem[{beAddr, beIdx + 2'd1}];
            end
            if (beIdx == 2'd3) begin
                beBusy    <= 1'b0;
                loadValid <= 1'b0;
            end
        end
    end

    always @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            reqsOpen    <= 0;
            accepted    <= 0;
            issued      <= 0;
            expExpect   <= 1'b0;
            storeCount  <= 0;
            returnCount <= 0;
            refillCount <= 0;
        end else begin
            if (feReqValid && feReqReady) begin
                expReq   <= feReq;
                accepted <= accepted + 1;
            end
            reqsOpen <= reqsOpen + int'(feReqValid && feReqReady)
                                 - int'(beCommandValid && beCommandReady);
            if (beCommandValid && beCommandReady) begin
                issued    <= issued + 1;
                expExpect <= expReq.dataBlock;
            end else if (beat && beIdx == 2'd3) begin
                expExpect <= 1'b0;
            end
            if (storeValid && storeReady) begin
                storeCount <= storeCount + 1;
            end
            if (returnDataValid && returnDataReady) begin
                returnCount <= returnCount + 1;
            end
            if (refillLeafValid && refillLeafReady) begin
                refillCount <= refillCount + 1;
            end
        end
    end

    aResetState: assert property (@(posedge Clock)
        $rose(rstN) |-> feReqReady && !beCommandValid && !storeValid && !returnDataValid
                        && !refillLeafValid && !expectingProgramData
    ) else begin
        errors = errors + 1;
        $display("error after reset feReqReady=%h beCommandValid=%h storeValid=%h",
                 $sampled(feReqReady), $sampled(beCommandValid), $sampled(storeValid));
    end

    aCommandValue: assert property (@(posedge Clock) disable iff (!rstN)
        beCommandValid && beCommandReady |-> beCommand == expReq
    ) else begin
        errors = errors + 1;
        $display("error beCommand=%h expected %h", $sampled(beCommand), $sampled(expReq));
    end

    aOneCommand: assert property (@(posedge Clock) disable iff (!rstN)
        beCommandValid && beCommandReady |-> reqsOpen == 1
    ) else begin
        errors = errors + 1;
        $display("a command was issued without exactly one open request");
    end

    aOneRequest: assert property (@(posedge Clock) disable iff (!rstN)
        feReqValid && feReqReady |-> reqsOpen == 0
    ) else begin
        errors = errors + 1;
        $display("a request was accepted before the previous command was issued");
    end

    aStoreData: assert property (@(posedge Clock) disable iff (!rstN)
        storeValid && storeReady |-> storeCount < storeWr && store == expStore[storeCount]
    ) else begin
        errors = errors + 1;
        $display("error store=%h expected %h", $sampled(store),
                 expStore[$sampled(storeCount)]);
    end

    aReturnData: assert property (@(posedge Clock) disable iff (!rstN)
        returnDataValid && returnDataReady |->
            returnCount < returnWr && returnData == expReturn[returnCount]
    ) else begin
        errors = errors + 1;
        $display("error returnData=%h expected %h", $sampled(returnData),
                 expReturn[$sampled(returnCount)]);
    end

    aRefillData: assert property (@(posedge Clock) disable iff (!rstN)
        refillLeafValid && refillLeafReady |->
            refillCount < refillWr && refillLeaf == expRefill[refillCount]
    ) else begin
        errors = errors + 1;
        $display("error refillLeaf=%h expected %h", $sampled(refillLeaf),
                 expRefill[$sampled(refillCount)]);
    end

    aExpecting: assert property (@(posedge Clock) disable iff (!rstN)
        expectingProgramData == expExpect
    ) else begin
        errors = errors + 1;
        $display("error expectingProgramData=%h expected %h",
                 $sampled(expectingProgramData), $sampled(expExpect));
    end

    // stalled streams keep valid and data
    aHoldCommand: assert property (@(posedge Clock) disable iff (!rstN)
        beCommandValid && !beCommandReady |=> beCommandValid && $stable(beCommand)
    ) else begin
        errors = errors + 1;
        $display("error beCommand=%h changed while stalled, was %h",
                 $sampled(beCommand), $past(beCommand));
    end

    aHoldStore: assert property (@(posedge Clock) disable iff (!rstN)
        storeValid && !storeReady |=> storeValid && $stable(store)
    ) else begin
        errors = errors + 1;
        $display("error store=%h changed while stalled, was %h",
                 $sampled(store), $past(store));
    end

    aHoldReturn: assert property (@(posedge Clock) disable iff (!rstN)
        returnDataValid && !returnDataReady |=> returnDataValid && $stable(returnData)
    ) else begin
        errors = errors + 1;
        $display("error returnData=%h changed while stalled, was %h",
                 $sampled(returnData), $past(returnData));
    end

    aHoldRefill: assert property (@(posedge Clock) disable iff (!rstN)
        refillLeafValid && !refillLeafReady |=> refillLeafValid && $stable(refillLeaf)
    ) else begin
        errors = errors + 1;
        $display("error refillLeaf=%h changed while stalled, was %h",
                 $sampled(refillLeaf), $past(refillLeaf));
    end

    task automatic sendRequest(input beCmd_t cmd, input logic isData,
                               input logic [`UORAM_ADDR_W-1:0] addr);
        feRequest_t req;
        req.command   = cmd;
        req.dataBlock = isData;
        req.addr      = addr;
        feReqValid <= 1'b1;
        feReq      <= req;
        do begin
            @(posedge Clock);
        end while (!feReqReady);
        feReqValid <= 1'b0;
    endtask

    // request is over once the controller takes requests again
    task automatic waitIdle();
        do begin
            @(posedge Clock);
        end while (!feReqReady);
    endtask

    task automatic writeDataBlock(input beCmd_t cmd, input logic [`UORAM_ADDR_W-1:0] addr);
        chunk_t word;
        int     i;
        sendRequest(cmd, 1'b1, addr);
        for (i = 0; i < chunks; i++) begin
            word = $random(seed);
            shadowChunk[int'(addr) * chunks + i] = word;
            expStore[storeWr] = word;
            storeWr++;
            dataInValid <= 1'b1;
            dataIn      <= word;
            do begin
                @(posedge Clock);
            end while (!dataInReady);
        end
        dataInValid <= 1'b0;
        waitIdle();
    endtask

    task automatic readDataBlock(input beCmd_t cmd, input logic [`UORAM_ADDR_W-1:0] addr);
        int i;
        for (i = 0; i < chunks; i++) begin
            expReturn[returnWr] = shadowChunk[int'(addr) * chunks + i];
            returnWr++;
        end
        sendRequest(cmd, 1'b1, addr);
        waitIdle();
    endtask

    // PLB evicts a full block of leaves, then the position-map block is stored
    task automatic storePosMap(input beCmd_t cmd, input logic [`UORAM_ADDR_W-1:0] addr);
        leaf_t leaf;
        leaf_t prevLeaf;
        int    i;
        for (i = 0; i < leaves; i++) begin
            leaf = $random(seed);
            shadowLeaf[int'(addr) * leaves + i] = leaf;
            if (i % 2 == 1) begin
                expStore[storeWr] = {leaf, prevLeaf};
                storeWr++;
            end
            prevLeaf = leaf;
            evictLeafValid <= 1'b1;
            evictLeaf      <= leaf;
            do begin
                @(posedge Clock);
            end while (!evictLeafReady);
        end
        evictLeafValid <= 1'b0;
        sendRequest(cmd, 1'b0, addr);
        waitIdle();
    endtask

    task automatic loadPosMap(input beCmd_t cmd, input logic [`UORAM_ADDR_W-1:0] addr);
        int i;
        for (i = 0; i < leaves; i++) begin
            expRefill[refillWr] = shadowLeaf[int'(addr) * leaves + i];
            refillWr++;
        end
        sendRequest(cmd, 1'b0, addr);
        waitIdle();
        // the refill funnel still drains its last chunk
        while (refillCount != refillWr) begin
            @(posedge Clock);
        end
    endtask

    task automatic closeTest(input string name);
        assert (issued == accepted && reqsOpen == 0) else begin
            errors = errors + 1;
            $display("%0d requests accepted but %0d commands issued", accepted, issued);
        end
        assert (storeCount == storeWr) else begin
            errors = errors + 1;
            $display("store moved %0d chunks instead of %0d", storeCount, storeWr);
        end
        assert (returnCount == returnWr) else begin
            errors = errors + 1;
            $display("returnData moved %0d chunks instead of %0d", returnCount, returnWr);
        end
        assert (refillCount == refillWr) else begin
            errors = errors + 1;
            $display("refillLeaf moved %0d leaves instead of %0d", refillCount, refillWr);
        end
        testsDone++;
        $display("test %0d %s finished, errors so far %0d", testsDone, name, errors);
    endtask

    initial begin
        #(numTests * cyclesPerTest * clkPeriod);
        $display("timeout, run stopped after %0d cycles", numTests * cyclesPerTest);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rstN           <= 1'b0;
        feReqValid     <= 1'b0;
        feReq          <= '0;
        dataInValid    <= 1'b0;
        dataIn         <= '0;
        evictLeafValid <= 1'b0;
        evictLeaf      <= '0;
        stallHeavy     <= 1'b0;
        repeat (2) @(posedge Clock);
        rstN <= 1'b1;
        repeat (3) @(posedge Clock);
        closeTest("reset state");

        writeDataBlock(cmdUpdate, 12'h3a5);
        closeTest("data write");
        readDataBlock(cmdRead, 12'h3a5);
        closeTest("data read");
        storePosMap(cmdAppend, 12'h017);
        closeTest("position-map store");
        loadPosMap(cmdRead, 12'h017);
        closeTest("position-map load");

        stallHeavy <= 1'b1;
        writeDataBlock(cmdAppend, 12'hc41);
        readDataBlock(cmdReadRmv, 12'hc41);
        closeTest("data round trip under back-pressure");

        $display("tests run %0d, errors %0d", testsDone, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uoramSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "uoramConsts.svh"

module uoramSubsystem (
    input  wire                          Clock,
    input  wire                          rstN,
    input  wire                          feReqValid,
    output logic                         feReqReady,
    input  wire uoramCmdPkg::feRequest_t feReq,
    output logic                         beCommandValid,
    input  wire                          beCommandReady,
    output uoramCmdPkg::feRequest_t      beCommand,
    output logic                         expectingProgramData,
    input  wire                          dataInValid,
    output logic                         dataInReady,
    input  wire uoramStreamPkg::chunk_t  dataIn,
    output logic                         returnDataValid,
    input  wire                          returnDataReady,
    output uoramStreamPkg::chunk_t       returnData,
    input  wire                          evictLeafValid,
    output logic                         evictLeafReady,
    input  wire uoramStreamPkg::leaf_t   evictLeaf,
    output logic                         refillLeafValid,
    input  wire                          refillLeafReady,
    output uoramStreamPkg::leaf_t        refillLeaf,
    output logic                         storeValid,
    input  wire                          storeReady,
    output uoramStreamPkg::chunk_t       store,
    input  wire                          loadValid,
    output logic                         loadReady,
    input  wire uoramStreamPkg::chunk_t  load
);

    import uoramStreamPkg::*;

    logic       switchReq;
    routeMode_t switchMode;
    logic       blockDone;

    // FIFO into the packing funnel
    logic       fifoOutValid;
    logic       fifoOutReady;
    leaf_t      fifoOutData;
    logic       packedValid;
    logic       packedReady;
    chunk_t     packedData;

    // router into the unpacking funnel
    logic       refillValid;
    logic       refillReady;
    chunk_t     refillData;

    uoramReqControl reqControl (
        .Clock          (Clock),
        .rstN           (rstN),
        .feReqValid     (feReqValid),
        .feReqReady     (feReqReady),
        .feReq          (feReq),
        .beCommandValid (beCommandValid),
        .beCommandReady (beCommandReady),
        .beCommand      (beCommand),
        .switchReq      (switchReq),
        .switchMode     (switchMode),
        .blockDone      (blockDone)
    );

    uoramDataRouter dataRouter (
        .Clock                (Clock),
        .rstN                 (rstN),
        .switchReq            (switchReq),
        .switchMode           (switchMode),
        .blockDone            (blockDone),
        .expectingProgramData (expectingProgramData),
        .dataInValid          (dataInValid),
        .dataInReady          (dataInReady),
        .dataIn               (dataIn),
        .returnValid          (returnDataValid),
        .returnReady          (returnDataReady),
        .returnData           (returnData),
        .packedValid          (packedValid),
        .packedReady          (packedReady),
        .packedData           (packedData),
        .refillValid          (refillValid),
        .refillReady          (refillReady),
        .refillData           (refillData),
        .storeValid           (storeValid),
        .storeReady           (storeReady),
        .storeData            (store),
        .loadValid            (loadValid),
        .loadReady            (loadReady),
        .loadData             (load)
    );

    leafFifo evictFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inValid  (evictLeafValid),
        .inReady  (evictLeafReady),
        .inData   (evictLeaf),
        .outValid (fifoOutValid),
        .outReady (fifoOutReady),
        .outData  (fifoOutData)
    );

    widthFunnel #(
        .inWidth  (`UORAM_LEAF_W),
        .outWidth (`UORAM_CHUNK_W)
    ) evictFunnel (
        .Clock    (Clock),
        .rstN     (rstN),
        .inValid  (fifoOutValid),
        .inReady  (fifoOutReady),
        .inData   (fifoOutData),
        .outValid (packedValid),
        .outReady (packedReady),
        .outData  (packedData)
    );

    widthFunnel #(
        .inWidth  (`UORAM_CHUNK_W),
        .outWidth (`UORAM_LEAF_W)
    ) refillFunnel (
        .Clock    (Clock),
        .rstN     (rstN),
        .inValid  (refillValid),
        .inReady  (refillReady),
        .inData   (refillData),
        .outValid (refillLeafValid),
        .outReady (refillLeafReady),
        .outData  (refillLeaf)
    );

endmodule

`default_nettype wire

//--- widthFunnel.sv
`timescale 1ns/1ps
`default_nettype none

module widthFunnel #(
    parameter int inWidth  = 16,
    parameter int outWidth = 32
) (
    input  wire                 Clock,
    input  wire                 rstN,
    input  wire                 inValid,
    output logic                inReady,
    input  wire [inWidth-1:0]   inData,
    output logic                outValid,
    input  wire                 outReady,
    output logic [outWidth-1:0] outData
);

    localparam int ratio = (inWidth < outWidth) ? outWidth / inWidth : inWidth / outWidth;
    localparam int slotW = (ratio > 1) ? $clog2(ratio) : 1;

    logic [slotW-1:0] slot;
    logic             accept;
    logic             emit;
    logic             lastSlot;

    assign accept   = inValid && inReady;
    assign emit     = outValid && outReady;
    assign lastSlot = (slot == slotW'(ratio - 1));

    generate
        if (inWidth < outWidth) begin : gGather
            // narrow words enter at the top, so the first one ends up lowest
            logic [outWidth-1:0] shiftReg;

            assign inReady = !outValid || outReady;
            assign outData = shiftReg;

            always_ff @(posedge Clock) begin
                if (accept) begin
                    shiftReg <= {inData, shiftReg[outWidth-1:inWidth]};
                end
            end

            always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                    slot     <= '0;
                    outValid <= 1'b0;
                end else begin
                    if (emit) begin
                        outValid <= 1'b0;
                    end
                    if (accept) begin
                        slot <= lastSlot ? '0 : slot + 1'b1;
                        if (lastSlot) begin
                            outValid <= 1'b1;
                        end
                    end
                end
            end
        end else begin : gSerial
            // wide word drains low slice first
            logic [inWidth-1:0] shiftReg;

            // reload as the last slice leaves
            assign inReady = !outValid || (outReady && lastSlot);
            assign outData = shiftReg[outWidth-1:0];

            always_ff @(posedge Clock) begin
                if (accept) begin
                    shiftReg <= inData;
                end else if (emit) begin
                    shiftReg <= shiftReg >> outWidth;
                end
            end

            always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                    slot     <= '0;
                    outValid <= 1'b0;
                end else if (accept) begin
                    slot     <= '0;
                    outValid <= 1'b1;
                end else if (emit) begin
                    slot <= slot + 1'b1;
                    if (lastSlot) begin
                        outValid <= 1'b0;
                    end
                end
            end
        end
    endgenerate

    aHoldOutput: assert property (
        @(posedge Clock) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outData)
    ) else $error("outData=%h changed while stalled", outData);

endmodule

`default_nettype wire

//--- leafFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uoramConsts.svh"

module leafFifo #(
    parameter int depth = `UORAM_BLOCK_LEAVES
) (
    input  wire                         Clock,
    input  wire                         rstN,
    input  wire                         inValid,
    output logic                        inReady,
    input  wire uoramStreamPkg::leaf_t  inData,
    output logic                        outValid,
    input  wire                         outReady,
    output uoramStreamPkg::leaf_t       outData
);

    import uoramStreamPkg::*;

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    leaf_t           mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            push;
    logic            pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inReady  = (count != cntW'(depth));
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + cntW'(push) - cntW'(pop);
        end
    end

    aCountBounded: assert property (
        @(posedge Clock) disable iff (!rstN)
        count <= cntW'(depth)
    ) else $error("count=%h exceeds depth=%h", count, depth);

endmodule

`default_nettype wire

//--- uoramDataRouter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uoramConsts.svh"

module uoramDataRouter (
    input  wire                          Clock,
    input  wire                          rstN,
    input  wire                          switchReq,
    input  wire uoramStreamPkg::routeMode_t switchMode,
    output logic                         blockDone,
    output logic                         expectingProgramData,
    // network in
    input  wire                          dataInValid,
    output logic                         dataInReady,
    input  wire uoramStreamPkg::chunk_t  dataIn,
    // network out
    output logic                         returnValid,
    input  wire                          returnReady,
    output uoramStreamPkg::chunk_t       returnData,
    // packed leaves from the evict funnel
    input  wire                          packedValid,
    output logic                         packedReady,
    input  wire uoramStreamPkg::chunk_t  packedData,
    // chunks for the refill funnel
    output logic                         refillValid,
    input  wire                          refillReady,
    output uoramStreamPkg::chunk_t       refillData,
    // backend store
    output logic                         storeValid,
    input  wire                          storeReady,
    output uoramStreamPkg::chunk_t       storeData,
    // backend load
    input  wire                          loadValid,
    output logic                         loadReady,
    input  wire uoramStreamPkg::chunk_t  loadData
);

    import uoramStreamPkg::*;

    localparam int cntW = $clog2(`UORAM_BLOCK_CHUNKS);

    routeMode_t      mode;
    logic [cntW-1:0] chunkCount;
    logic            isProgStore;
    logic            isPosMapStore;
    logic            isDataLoad;
    logic            isPosMapLoad;
    logic            beat;

    assign isProgStore   = (mode == modeProgStore);
    assign isPosMapStore = (mode == modePosMapStore);
    assign isDataLoad    = (mode == modeDataLoad);
    assign isPosMapLoad  = (mode == modePosMapLoad);

    assign expectingProgramData = isProgStore || isDataLoad;

    // network or evict funnel into the backend
    assign storeValid  = (isProgStore && dataInValid) || (isPosMapStore && packedValid);
    assign storeData   = isProgStore ? dataIn : packedData;
    assign dataInReady = isProgStore && storeReady;
    assign packedReady = isPosMapStore && storeReady;

    // backend out to the network or the refill funnel
    assign returnValid = isDataLoad && loadValid;
    assign returnData  = loadData;
    assign refillValid = isPosMapLoad && loadValid;
    assign refillData  = loadData;
    assign loadReady   = (isDataLoad && returnReady) || (isPosMapLoad && refillReady);

    // one backend-side chunk moved
    assign beat      = (storeValid && storeReady) || (loadValid && loadReady);
    assign blockDone = beat && (chunkCount == cntW'(`UORAM_BLOCK_CHUNKS - 1));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mode       <= modeIdle;
            chunkCount <= '0;
        end else if (switchReq) begin
            mode <= switchMode;
        end else if (blockDone) begin
            mode       <= modeIdle;
            chunkCount <= '0;
        end else if (beat) begin
            chunkCount <= chunkCount + 1'b1;
        end
    end

    // the network side closes together with the block
    aDataInClosesWithBlock: assert property (
        @(posedge Clock) disable iff (!rstN)
        blockDone |=> !dataInReady
    ) else $error("dataInReady=%h after blockDone", $sampled(dataInReady));

    // the controller must not switch while a block is in flight
    aSwitchOnlyIdle: assert property (
        @(posedge Clock) disable iff (!rstN)
        switchReq |-> mode == modeIdle
    ) else $error("switchReq=%h with mode=%h", switchReq, mode);

endmodule

`default_nettype wire

//--- uoramReqControl.sv
`timescale 1ns/1ps
`default_nettype none

module uoramReqControl (
    input  wire                           Clock,
    input  wire                           rstN,
    // front-end request
    input  wire                           feReqValid,
    output logic                          feReqReady,
    input  wire uoramCmdPkg::feRequest_t  feReq,
    // command to the backend
    output logic                          beCommandValid,
    input  wire                           beCommandReady,
    output uoramCmdPkg::feRequest_t       beCommand,
    // router control
    output logic                          switchReq,
    output uoramStreamPkg::routeMode_t    switchMode,
    input  wire                           blockDone
);

    import uoramCmdPkg::*;
    import uoramStreamPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stTransfer
    } ctrlState_t;

    ctrlState_t state;
    feRequest_t reqReg;

    // transfer mode for a request
    function automatic routeMode_t decodeMode(input feRequest_t req);
        logic isRead;
        isRead = (req.command == cmdRead) || (req.command == cmdReadRmv);
        if (req.dataBlock) begin
            return isRead ? modeDataLoad : modeProgStore;
        end
        return isRead ? modePosMapLoad : modePosMapStore;
    endfunction

    assign feReqReady     = (state == stIdle);
    assign beCommandValid = (state == stIssue);
    assign beCommand      = reqReg;

    // the router switches on the same edge as the command handshake
    assign switchReq  = beCommandValid && beCommandReady;
    assign switchMode = decodeMode(reqReg);

    always_ff @(posedge Clock) begin
        if (feReqValid && feReqReady) begin
            reqReg <= feReq;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (feReqValid) begin
                        state <= stIssue;
                    end
                end
                stIssue: begin
                    if (beCommandReady) begin
                        state <= stTransfer;
                    end
                end
                stTransfer: begin
                    // wait for the router to move the whole block
                    if (blockDone) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // the router may only finish a block that this controller started
    aBlockDoneInTransfer: assert property (
        @(posedge Clock) disable iff (!rstN)
        blockDone |-> state == stTransfer
    ) else $error("blockDone=%h outside transfer, state=%h", blockDone, state);

endmodule

`default_nettype wire

//--- uoramStreamPkg.sv
`default_nettype none

`include "uoramConsts.svh"

package uoramStreamPkg;

    typedef logic [`UORAM_CHUNK_W-1:0] chunk_t;
    typedef logic [`UORAM_LEAF_W-1:0] leaf_t;

    // which streams the router connects for the current block
    typedef enum logic [2:0] {
        modeIdle        = 3'd0,
        modeProgStore   = 3'd1,
        modeDataLoad    = 3'd2,
        modePosMapLoad  = 3'd3,
        modePosMapStore = 3'd4
    } routeMode_t;

endpackage

`default_nettype wire

//--- uoramCmdPkg.sv
`default_nettype none

`include "uoramConsts.svh"

package uoramCmdPkg;

    // backend command encoding
    typedef enum logic [1:0] {
        cmdUpdate  = 2'd0,
        cmdAppend  = 2'd1,
        cmdRead    = 2'd2,
        cmdReadRmv = 2'd3
    } beCmd_t;

    // front-end request, also sent unchanged to the backend as a command
    typedef struct packed {
        beCmd_t                   command;
        // 0 selects a position-map block
        logic                     dataBlock;
        logic [`UORAM_ADDR_W-1:0] addr;
    } feRequest_t;

endpackage

`default_nettype wire

//--- uoramConsts.svh
`ifndef UORAM_CONSTS_SVH
`define UORAM_CONSTS_SVH

// stream widths
`define UORAM_CHUNK_W 32
`define UORAM_LEAF_W 16

// chunks per data block and leaves per position-map block
`define UORAM_BLOCK_CHUNKS 4
`define UORAM_BLOCK_LEAVES 8

// backend block address
`define UORAM_ADDR_W 12

`endif
